/* list.f */
+incdir+verilog
+incdir+tb
verilog/baser_code_pkg.sv
verilog/eth_frame_pkg.sv
verilog/fcs_if.sv
verilog/baser_block_decoder.sv
verilog/eth_fcs_checker.sv
verilog/baser_rx_framer.sv
verilog/baser_rx_top.sv
tb/tb_baser_rx.sv

/* Bender.yml */
package:
  name: baser_rx

sources:
  - include_dirs:
      - verilog
      - tb
    files:
      - verilog/baser_code_pkg.sv
      - verilog/eth_frame_pkg.sv
      - verilog/fcs_if.sv
      - verilog/baser_block_decoder.sv
      - verilog/eth_fcs_checker.sv
      - verilog/baser_rx_framer.sv
      - verilog/baser_rx_top.sv
      - tb/tb_baser_rx.sv

/* tb/baser_rx_tb_util.svh */
// Testbench helpers for the 10GBASE-R receiver, payload LFSR, bytewise CRC-32 and value check
`ifndef BASER_RX_TB_UTIL_SVH
`define BASER_RX_TB_UTIL_SVH

// galois lfsr x^16+x^14+x^13+x^11+1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// one lfsr step per bit, lsb first
task automatic take_random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
        b[i]       = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

// reflected crc-32 of poly 0x04c11db7, one byte at a time
function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc ^ {24'd0, b};
    for (int i = 0; i < 8; i++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
    end
    return c;
endfunction

task automatic check_value(input string what, input logic [63:0] got,
                           input logic [63:0] expected);
    check_count++;
    if (got !== expected) begin
        error_count++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
endtask

`endif

/* tb/tb_baser_rx.sv */
// Testbench for the 10GBASE-R frame receiver, table driven frames against an output monitor
`include "baser_rx_defines.svh"

module tb_baser_rx
    import baser_code_pkg::*, eth_frame_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_FRAMES = 13;
    localparam int GAP        = 4;    // idle blocks after each frame
    localparam int MAX_CYC    = 1024;

    typedef struct packed {
        logic [15:0] len;      // payload bytes, fcs not counted
        logic        corrupt;  // flip one fcs bit
        logic        inject;   // control block in place of data word 2
        logic        enable;
        logic        exp_user;
        logic        exp_fcs;
    } frame_row_t;

    localparam frame_row_t FRAME_TABLE [NUM_FRAMES] = '{
        '{16'd60, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},  // terminate after 0 bytes
        '{16'd21, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{16'd46, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{16'd15, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{16'd64, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{16'd33, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},  // first long terminate
        '{16'd18, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{16'd51, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{16'd40, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},  // bad fcs, short path
        '{16'd35, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},  // bad fcs, long path
        '{16'd48, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0},
        '{16'd30, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},  // receiver disabled
        '{16'd26, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0}
    };

    localparam logic [7:0] TERM_TYPE [8] = '{
        `BASER_BT_TERM_0, `BASER_BT_TERM_1, `BASER_BT_TERM_2, `BASER_BT_TERM_3,
        `BASER_BT_TERM_4, `BASER_BT_TERM_5, `BASER_BT_TERM_6, `BASER_BT_TERM_7
    };

    logic      clk = 1'b0;
    logic      reset_crc;
    blk_data_t rx_data;
    sync_hdr_t rx_hdr;
    logic      rx_enable;
    blk_data_t rx_tdata;
    keep_t     rx_tkeep;
    logic      rx_tvalid;
    logic      rx_tlast;
    logic      rx_tuser;
    logic      start_packet;
    logic      bad_frame;
    logic      bad_fcs;
    logic      bad_block;

    int          error_count = 0;
    int          check_count = 0;
    int          cyc         = 0;  // rising edges so far
    logic [15:0] lfsr_state  = 16'd85;
    logic        exp_start [MAX_CYC];
    logic        exp_bad   [MAX_CYC];
    frame_row_t  exp_frame_q [$];  // len is the byte count expected at the output
    logic [7:0]  exp_byte_q [$];
    logic [7:0]  frame_bytes [128];
    frame_row_t  cur;
    int          cur_left    = 0;  // zero between frames

    `include "baser_rx_tb_util.svh"

    baser_rx_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic drive_block(input sync_hdr_t hdr, input blk_data_t data);
        @(negedge clk);
        rx_hdr  = hdr;
        rx_data = data;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) drive_block(`BASER_SYNC_CTRL, {56'd0, `BASER_BT_CTRL});
    endtask

    task automatic send_frame(input frame_row_t row);
        int          total;
        logic [31:0] crc;
        blk_data_t   word;
        frame_row_t  want;
        total = row.len + 4;
        crc   = '1;
        for (int i = 0; i < row.len; i++) begin
            take_random_byte(frame_bytes[i]);
            crc = crc32_update(crc, frame_bytes[i]);
        end
        for (int i = 0; i < 4; i++) begin
            frame_bytes[row.len + i] = ~crc[i*8 +: 8]; // complemented, low byte first
        end
        frame_bytes[row.len][0] ^= row.corrupt;
        want     = row;
        want.len = row.inject ? 16'd16 : row.len; // cut after data words 0 and 1
        if (row.enable) begin
            exp_frame_q.push_back(want);
            for (int i = 0; i < want.len; i++) begin
                exp_byte_q.push_back(frame_bytes[i]);
            end
        end
        rx_enable = row.enable;
        drive_block(`BASER_SYNC_CTRL, {8'hd5, {6{8'h55}}, `BASER_BT_START_0});
        exp_start[cyc + 2] = 1'b1;
        for (int w = 0; w < total / 8; w++) begin
            for (int b = 0; b < 8; b++) begin
                word[b*8 +: 8] = frame_bytes[w*8 + b];
            end
            if (row.inject && w == 2) begin
                drive_block(`BASER_SYNC_CTRL, {56'd0, `BASER_BT_CTRL});
            end else begin
                drive_block(`BASER_SYNC_DATA, word);
            end
        end
        word = {56'd0, TERM_TYPE[total % 8]};
        for (int b = 0; b < total % 8; b++) begin
            word[(b+1)*8 +: 8] = frame_bytes[total - total % 8 + b];
        end
        drive_block(`BASER_SYNC_CTRL, word);
        drive_idle(GAP);
    endtask

    // outputs move on the rising edge
    always @(negedge clk) begin : monitor
        blk_data_t want_word;
        blk_data_t lane_bits;
        keep_t     want_keep;
        int        nbytes;
        check_value("start_packet", start_packet, exp_start[cyc]);
        check_value("bad_block", bad_block, exp_bad[cyc]);
        if (!(rx_tvalid && rx_tlast)) begin
            check_value("bad_frame", bad_frame, 1'b0);
            check_value("bad_fcs", bad_fcs, 1'b0);
        end
        if (rx_tvalid && cur_left == 0) begin
            if (exp_frame_q.size() == 0) begin
                error_count++;
                $display("output beat at %0t while no frame was expected", $time);
            end else begin
                cur      = exp_frame_q.pop_front();
                cur_left = cur.len;
            end
        end
        if (rx_tvalid && cur_left != 0) begin
            nbytes    = (cur_left < 8) ? cur_left : 8;
            want_word = '0;
            lane_bits = '0;
            want_keep = '0;
            for (int b = 0; b < nbytes; b++) begin
                want_word[b*8 +: 8] = exp_byte_q.pop_front();
                lane_bits[b*8 +: 8] = 8'hff;
                want_keep[b]        = 1'b1;
            end
            cur_left = cur_left - nbytes;
            check_value("rx_tkeep", rx_tkeep, want_keep);
            check_value("rx_tdata", rx_tdata & lane_bits, want_word);
            check_value("rx_tlast", rx_tlast, cur_left == 0);
            check_value("rx_tuser", rx_tuser, cur_left == 0 && cur.exp_user);
            if (rx_tlast) begin
                check_value("bad_frame", bad_frame, cur.exp_user);
                check_value("bad_fcs", bad_fcs, cur.exp_fcs);
                cur_left = 0; // resync after an early last
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 16 + 20 + 50; // reset, bad block blocks and drain
        for (int f = 0; f < NUM_FRAMES; f++) begin
            limit += 2 + (FRAME_TABLE[f].len + 4) / 8 + GAP;
        end
        #(limit * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d clock cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        for (int i = 0; i < MAX_CYC; i++) begin
            exp_start[i] = 1'b0;
            exp_bad[i]   = 1'b0;
        end
        reset_crc = 1'b1;
        rx_enable = 1'b1;
        rx_hdr    = `BASER_SYNC_CTRL;
        rx_data   = {56'd0, `BASER_BT_CTRL};
        repeat (16) @(negedge clk);
        reset_crc = 1'b0;
        drive_idle(4);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(FRAME_TABLE[f]);
        end
        rx_enable = 1'b1;
        // header 00, then a control block with an unknown type byte
        drive_block(2'b00, 64'h0123456789abcdef);
        exp_bad[cyc + 1] = 1'b1;
        drive_idle(2);
        drive_block(`BASER_SYNC_CTRL, {56'd0, 8'h5a});
        exp_bad[cyc + 1] = 1'b1;
        drive_idle(2);
        while (cur_left != 0 || exp_frame_q.size() != 0) begin
            drive_idle(1);
        end
        drive_idle(4);
        check_value("payload bytes left over", exp_byte_q.size(), 0);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/baser_rx_top.sv */
// 10GBASE-R frame receiver top wiring the decoder, CRC-32 checker and framer
`include "baser_rx_defines.svh"

module baser_rx_top
    import baser_code_pkg::*, eth_frame_pkg::*;
(
    input  logic      clk,
    input  logic      reset_crc,
    input  blk_data_t rx_data,
    input  sync_hdr_t rx_hdr,
    input  logic      rx_enable,
    output blk_data_t rx_tdata,
    output keep_t     rx_tkeep,
    output logic      rx_tvalid,
    output logic      rx_tlast,
    output logic      rx_tuser,
    output logic      start_packet,
    output logic      bad_frame,
    output logic      bad_fcs,
    output logic      bad_block
);

    blk_data_t blk_data; // stage d0
    blk_kind_t blk_kind;

    fcs_if fcs_bus ();

    baser_block_decoder u_decoder (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .rx_data      (rx_data),
        .rx_hdr       (rx_hdr),
        .blk_data     (blk_data),
        .blk_kind     (blk_kind),
        .start_packet (start_packet),
        .bad_block    (bad_block)
    );

    eth_fcs_checker u_fcs (
        .clk (clk),
        .fcs (fcs_bus.crc_checker)
    );

    baser_rx_framer u_framer (
        .clk       (clk),
        .reset_crc (reset_crc),
        .blk_data  (blk_data),
        .blk_kind  (blk_kind),
        .rx_enable (rx_enable),
        .fcs       (fcs_bus.framer),
        .rx_tdata  (rx_tdata),
        .rx_tkeep  (rx_tkeep),
        .rx_tvalid (rx_tvalid),
        .rx_tlast  (rx_tlast),
        .rx_tuser  (rx_tuser),
        .bad_frame (bad_frame),
        .bad_fcs   (bad_fcs)
    );

endmodule

/* verilog/baser_rx_framer.sv */
// Frame state machine, strips preamble and FCS and drives the stream outputs
`include "baser_rx_defines.svh"

module baser_rx_framer
    import baser_code_pkg::*, eth_frame_pkg::*;
(
    input  logic      clk,
    input  logic      reset_crc,
    input  blk_data_t blk_data,
    input  blk_kind_t blk_kind,
    input  logic      rx_enable,
    fcs_if.framer     fcs,
    output blk_data_t rx_tdata,
    output keep_t     rx_tkeep,
    output logic      rx_tvalid,
    output logic      rx_tlast,
    output logic      rx_tuser,
    output logic      bad_frame,
    output logic      bad_fcs
);

    blk_data_t blk_data_d1;
    blk_kind_t blk_kind_d1;
    rx_state_t state;
    rx_state_t state_next;

    keep_t      tkeep_next;
    logic       tvalid_next;
    logic       tlast_next;
    logic       tuser_next;
    logic       bad_frame_next;
    logic       bad_fcs_next;
    logic       fcs_ok;
    logic [2:0] res_idx;

    // n low byte lanes set
    function automatic keep_t lane_mask(input logic [3:0] n);
        keep_t m;
        for (int b = 0; b < `BASER_KEEP_W; b++) begin
            m[b] = (b < n);
        end
        return m;
    endfunction

    assign fcs.data = blk_data;

    always_comb begin
        state_next     = state;
        fcs.clear      = 1'b0;
        tkeep_next     = '0;
        tvalid_next    = 1'b0;
        tlast_next     = 1'b0;
        tuser_next     = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next   = 1'b0;
        fcs_ok         = 1'b1;
        res_idx        = blk_kind[2:0] - 3'd1; // term 0 wraps to lane 7

        case (state)
            ST_IDLE: begin
                fcs.clear = 1'b1;
                if (blk_kind_d1 == BLK_START && rx_enable) begin
                    fcs.clear  = 1'b0; // first payload word is in d0 now
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                tkeep_next  = '1;
                tvalid_next = 1'b1;
                if (blk_kind[3]) begin
                    fcs.clear = 1'b1;
                    if (blk_kind[2:0] <= 3'd4) begin
                        // fcs sits in this beat and the terminate block
                        tkeep_next = lane_mask(4'd4 + {1'b0, blk_kind[2:0]});
                        tlast_next = 1'b1;
                        if (blk_kind == BLK_TERM_0) begin
                            fcs_ok = fcs.match_saved[res_idx];
                        end else begin
                            fcs_ok = fcs.match[res_idx];
                        end
                        state_next = ST_IDLE;
                    end else begin
                        state_next = ST_LAST;
                    end
                end else if (blk_kind != BLK_DATA) begin
                    // control or error inside the frame
                    fcs.clear      = 1'b1;
                    tlast_next     = 1'b1;
                    tuser_next     = 1'b1;
                    bad_frame_next = 1'b1;
                    state_next     = ST_IDLE;
                end
            end
            ST_LAST: begin
                fcs.clear   = 1'b1;
                tvalid_next = 1'b1;
                tlast_next  = 1'b1;
                tkeep_next  = lane_mask({1'b0, blk_kind_d1[2:0]} - 4'd4);
                res_idx     = blk_kind_d1[2:0] - 3'd1;
                fcs_ok      = fcs.match_saved[res_idx];
                state_next  = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase

        if (tlast_next && !fcs_ok) begin
            tuser_next     = 1'b1;
            bad_frame_next = 1'b1;
            bad_fcs_next   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        blk_data_d1 <= blk_data;
        rx_tdata    <= blk_data_d1;
        rx_tkeep    <= tkeep_next;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state       <= ST_IDLE;
            blk_kind_d1 <= BLK_IDLE;
            rx_tvalid   <= 1'b0;
            rx_tlast    <= 1'b0;
            rx_tuser    <= 1'b0;
            bad_frame   <= 1'b0;
            bad_fcs     <= 1'b0;
        end else begin
            state       <= state_next;
            blk_kind_d1 <= blk_kind;
            rx_tvalid   <= tvalid_next;
            rx_tlast    <= tlast_next;
            rx_tuser    <= tuser_next;
            bad_frame   <= bad_frame_next;
            bad_fcs     <= bad_fcs_next;
        end
    end

endmodule

/* verilog/eth_fcs_checker.sv */
// Running CRC-32 over 64-bit words with residue match flags for each end lane
`include "baser_rx_defines.svh"

module eth_fcs_checker
    import baser_code_pkg::*, eth_frame_pkg::*;
(
    input  logic       clk,
    fcs_if.crc_checker fcs
);

    localparam crc_t RESIDUE [`BASER_KEEP_W] = '{
        `ETH_CRC_RES_0, `ETH_CRC_RES_1, `ETH_CRC_RES_2, `ETH_CRC_RES_3,
        `ETH_CRC_RES_4, `ETH_CRC_RES_5, `ETH_CRC_RES_6, `ETH_CRC_RES_7
    };

    crc_t crc_state;
    crc_t crc_next;

    // reflected galois crc with the lsb of the word going in first
    function automatic crc_t crc_step(input crc_t state, input blk_data_t data);
        crc_t c;
        c = state;
        for (int i = 0; i < `BASER_DATA_W; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_comb begin
        crc_next = crc_step(crc_state, fcs.data);
        for (int i = 0; i < `BASER_KEEP_W; i++) begin
            fcs.match[i] = (crc_next == RESIDUE[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (fcs.clear) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_next;
        end
        fcs.match_saved <= fcs.match; // for ends decided a cycle late
    end

endmodule

/* verilog/baser_block_decoder.sv */
// 64b/66b block decoder, masks terminate data and classifies each block
`include "baser_rx_defines.svh"

module baser_block_decoder
    import baser_code_pkg::*;
(
    input  logic      clk,
    input  logic      reset_crc,
    input  blk_data_t rx_data,
    input  sync_hdr_t rx_hdr,
    output blk_data_t blk_data,
    output blk_kind_t blk_kind,
    output logic      start_packet,
    output logic      bad_block
);

    blk_data_t data_masked;
    blk_kind_t kind_next;
    logic      bad_next;

    // coarse class from the upper nibble of the type byte
    function automatic blk_kind_t nibble_kind(input logic [3:0] n);
        blk_kind_t k;
        case (n)
            4'(`BASER_BT_CTRL >> 4),
            4'(`BASER_BT_OS_4 >> 4),
            4'(`BASER_BT_START_4 >> 4),
            4'(`BASER_BT_OS_START >> 4),
            4'(`BASER_BT_OS_04 >> 4),
            4'(`BASER_BT_OS_0 >> 4):    k = BLK_IDLE; // lane 4 starts count as idle
            4'(`BASER_BT_START_0 >> 4): k = BLK_START;
            default: begin
                if (n[3]) begin
                    k = blk_kind_t'({1'b1, n[2:0]});
                end else begin
                    k = BLK_ERROR;
                end
            end
        endcase
        return k;
    endfunction

    function automatic logic legal_type(input logic [7:0] t);
        logic ok;
        case (t)
            `BASER_BT_CTRL, `BASER_BT_OS_4, `BASER_BT_START_4, `BASER_BT_OS_START,
            `BASER_BT_OS_04, `BASER_BT_START_0, `BASER_BT_OS_0,
            `BASER_BT_TERM_0, `BASER_BT_TERM_1, `BASER_BT_TERM_2, `BASER_BT_TERM_3,
            `BASER_BT_TERM_4, `BASER_BT_TERM_5, `BASER_BT_TERM_6,
            `BASER_BT_TERM_7: ok = 1'b1;
            default:          ok = 1'b0;
        endcase
        return ok;
    endfunction

    // drop the type byte of a terminate and zero the lanes past its data
    always_comb begin
        data_masked = rx_data;
        if (rx_hdr == `BASER_SYNC_CTRL && rx_data[7]) begin
            data_masked = rx_data >> 8;
            for (int b = 0; b < `BASER_KEEP_W; b++) begin
                if (b >= rx_data[6:4]) begin
                    data_masked[b*8 +: 8] = 8'd0;
                end
            end
        end
    end

    always_comb begin
        kind_next = BLK_ERROR;
        bad_next  = 1'b0;
        if (rx_hdr == `BASER_SYNC_DATA) begin
            kind_next = BLK_DATA;
        end else if (rx_hdr == `BASER_SYNC_CTRL) begin
            kind_next = nibble_kind(rx_data[7:4]);
            if (!legal_type(rx_data[7:0])) begin
                kind_next = BLK_ERROR; // unknown type byte
                bad_next  = 1'b1;
            end
        end else begin
            bad_next = 1'b1; // header 00 or 11
        end
    end

    always_ff @(posedge clk) begin
        blk_data <= data_masked;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            blk_kind     <= BLK_IDLE;
            bad_block    <= 1'b0;
            start_packet <= 1'b0;
        end else begin
            blk_kind     <= kind_next;
            bad_block    <= bad_next;
            start_packet <= (blk_kind == BLK_START); // d0 holds the start
        end
    end

endmodule

/* verilog/fcs_if.sv */
// Link between the frame state machine and the CRC-32 checker
`include "baser_rx_defines.svh"

interface fcs_if;

    logic [`BASER_DATA_W-1:0] data;        // stage d0 word
    logic                     clear;       // restart crc at next edge
    logic [`BASER_KEEP_W-1:0] match;
    logic [`BASER_KEEP_W-1:0] match_saved;

    modport framer (
        output data, clear,
        input  match, match_saved
    );

    modport crc_checker (
        input  data, clear,
        output match, match_saved
    );

endinterface

/* verilog/eth_frame_pkg.sv */
// Ethernet frame datapath types for the stream output and the FCS check
`include "baser_rx_defines.svh"

package eth_frame_pkg;

    typedef logic [`BASER_KEEP_W-1:0] keep_t;
    typedef logic [31:0]              crc_t;
    typedef logic [`BASER_KEEP_W-1:0] crc_match_t; // one flag per end position

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PAYLOAD = 2'd1,
        ST_LAST    = 2'd2
    } rx_state_t;

endpackage

/* verilog/baser_code_pkg.sv */
// 64b/66b line code types shared by the block decoder and the framer
`include "baser_rx_defines.svh"

package baser_code_pkg;

    typedef logic [`BASER_DATA_W-1:0] blk_data_t;
    typedef logic [`BASER_HDR_W-1:0]  sync_hdr_t;

    // decoded block class, terminates carry their byte count in the low bits
    typedef enum logic [3:0] {
        BLK_IDLE   = 4'd0,
        BLK_ERROR  = 4'd1,
        BLK_START  = 4'd2,
        BLK_DATA   = 4'd4,
        BLK_TERM_0 = 4'd8,
        BLK_TERM_1 = 4'd9,
        BLK_TERM_2 = 4'd10,
        BLK_TERM_3 = 4'd11,
        BLK_TERM_4 = 4'd12,
        BLK_TERM_5 = 4'd13,
        BLK_TERM_6 = 4'd14,
        BLK_TERM_7 = 4'd15
    } blk_kind_t;

endpackage

/* verilog/baser_rx_defines.svh */
// 10GBASE-R receiver constants for widths, sync headers, block types and CRC-32
`ifndef BASER_RX_DEFINES_SVH
`define BASER_RX_DEFINES_SVH

`define BASER_DATA_W 64
`define BASER_HDR_W  2
`define BASER_KEEP_W 8

`define BASER_SYNC_DATA 2'b10
`define BASER_SYNC_CTRL 2'b01

// legal control block type bytes
`define BASER_BT_CTRL     8'h1e
`define BASER_BT_OS_4     8'h2d
`define BASER_BT_START_4  8'h33
`define BASER_BT_OS_START 8'h66
`define BASER_BT_OS_04    8'h55
`define BASER_BT_START_0  8'h78
`define BASER_BT_OS_0     8'h4b
`define BASER_BT_TERM_0   8'h87
`define BASER_BT_TERM_1   8'h99
`define BASER_BT_TERM_2   8'haa
`define BASER_BT_TERM_3   8'hb4
`define BASER_BT_TERM_4   8'hcc
`define BASER_BT_TERM_5   8'hd2
`define BASER_BT_TERM_6   8'he1
`define BASER_BT_TERM_7   8'hff

`define ETH_CRC_POLY 32'hedb88320 // reflected 0x04c11db7

// crc state after a good frame ending n+1 bytes into the last word, zero padded
`define ETH_CRC_RES_0 (~32'h6b87b1ec)
`define ETH_CRC_RES_1 (~32'he38a6876)
`define ETH_CRC_RES_2 (~32'he60914ae)
`define ETH_CRC_RES_3 (~32'h6522df69)
`define ETH_CRC_RES_4 (~32'h9d6cdf7e)
`define ETH_CRC_RES_5 (~32'hb1c2a1a3)
`define ETH_CRC_RES_6 (~32'hc622f71d)
`define ETH_CRC_RES_7 (~32'h2144df1c)

`endif
